//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := tb_ir_reg_if
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
src/ir_reg_pkg.sv
src/ir_cmd_regs.sv
src/ir_cfg_regs.sv
src/ir_repeat_seq.sv
src/ir_readback.sv
src/ir_reg_if.sv
sim/ir_reg_if_props.sv
sim/tb_ir_reg_if.sv

//--- sim/ir_reg_if_props.sv
// concurrent properties of the IR register block, bound into every ir_reg_if instance
`timescale 1ns/1ps
module ir_reg_if_props (
	input logic                 REG_CLK_i,
	input logic                 RST_i,
	input ir_reg_pkg::reg_adr_e reg_adr_i,
	input logic                 int_clr_o,
	input logic                 start_o,
	input logic                 start_clr_i,
	input logic                 rpt_start,
	input logic                 mem_we_o
);
	import ir_reg_pkg::*;

	// interrupt clear is a single-cycle pulse
	a_int_clr_pulse: assert property (@(posedge REG_CLK_i) disable iff (RST_i)
		int_clr_o |=> !int_clr_o)
		else $error("int_clr_o high for more than one cycle");

	a_start_held: assert property (@(posedge REG_CLK_i) disable iff (RST_i)
		(start_clr_i && !rpt_start) |-> !start_o)
		else $error("start_o high during start clear");

	// writes only reach memory inside 60-7F
	a_mem_window: assert property (@(posedge REG_CLK_i) disable iff (RST_i)
		mem_we_o |-> (reg_adr_i[6] && reg_adr_i[5]))
		else $error("mem_we_o outside the code window");

endmodule

bind ir_reg_if ir_reg_if_props u_props (
	.REG_CLK_i   (REG_CLK_i),
	.RST_i       (RST_i),
	.reg_adr_i   (reg_adr_i),
	.int_clr_o   (int_clr_o),
	.start_o     (start_o),
	.start_clr_i (start_clr_i),
	.rpt_start   (rpt_start),
	.mem_we_o    (mem_we_o)
);

//--- sim/tb_ir_reg_if.sv
// directed testbench for the IR register block; run the top module tb_ir_reg_if from compile.f
`timescale 1ns/1ps
module tb_ir_reg_if;
	import ir_reg_pkg::*;

	localparam int MEM_AW     = 11;
	localparam int RPT_N      = 20;    // repeat delay used by the repeat test
	localparam int MAX_CYCLES = 3000;  // tests need well under 1500 cycles

	localparam logic [7:0]  HI_MASK  = 8'((1 << (MEM_AW - 8)) - 1);
	localparam logic [15:0] END_MASK = 16'((1 << MEM_AW) - 1);

	// settings registers in test order
	localparam logic [6:0] CFG_ADR [13] = '{
		ADR_RPT_DEL_0, ADR_RPT_DEL_1, ADR_RPT_DEL_2,
		ADR_CRR_CYC_LEN_LSB, ADR_CRR_CYC_LEN_MSB,
		ADR_DUTY_LIMIT_LSB, ADR_DUTY_LIMIT_MSB,
		ADR_CODE_BGN_LSB, ADR_CODE_BGN_MSB,
		ADR_CODE_END_LSB, ADR_CODE_END_MSB,
		ADR_RPT_LEN_RX_CTRL, ADR_CODE_IDX
	};
	localparam logic [4:0] WIN_OFFS [3] = '{5'd0, 5'd13, 5'd31};

	logic              clk;
	logic              rst;
	reg_adr_e          reg_adr;
	logic [7:0]        reg_wd;
	logic              reg_we;
	logic [7:0]        reg_rd;
	logic              sw_rst_o, clk_en_o, mode_o, start_o, stop_o;
	logic              int_en_o, rx_gpio_en_o, rx_pol_inv_o, int_clr_o;
	logic              start_clr, stop_clr, busy, irq;
	logic [15:0]       tx_crr_len, duty_limit, rx_crr_len;
	logic [7:0]        rpt_len_rx_ctrl;
	logic [MEM_AW-1:0] code_bgn, tx_code_end, rx_code_end;
	logic              mem_we;
	logic [MEM_AW-1:0] mem_adr;
	logic [7:0]        mem_wd, mem_rd;

	int         seed;
	int         cycles;
	int         checks;
	int         errors;
	logic [7:0] cfg_val [13];  // last byte written to each settings register

	ir_reg_if #(.MEM_ADR_WIDTH(MEM_AW)) dut (
		.REG_CLK_i (clk), .RST_i (rst),
		.reg_adr_i (reg_adr), .reg_wd_i (reg_wd), .reg_we_i (reg_we), .reg_rd_o (reg_rd),
		.sw_rst_o (sw_rst_o), .clk_en_o (clk_en_o), .mode_o (mode_o),
		.start_o (start_o), .start_clr_i (start_clr),
		.stop_o (stop_o), .stop_clr_i (stop_clr), .busy_i (busy),
		.int_en_o (int_en_o), .rx_gpio_en_o (rx_gpio_en_o), .rx_pol_inv_o (rx_pol_inv_o),
		.int_i (irq), .int_clr_o (int_clr_o),
		.tx_crr_cyc_len_o (tx_crr_len), .duty_limit_o (duty_limit),
		.rpt_len_rx_ctrl_o (rpt_len_rx_ctrl),
		.code_bgn_adr_o (code_bgn), .tx_code_end_adr_o (tx_code_end),
		.rx_crr_cyc_len_i (rx_crr_len), .rx_code_end_adr_i (rx_code_end),
		.mem_we_o (mem_we), .mem_adr_o (mem_adr), .mem_wd_o (mem_wd), .mem_rd_i (mem_rd)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// **************************************************
	// host access and checking
	// **************************************************
	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED time %0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic start_write(input logic [6:0] adr, input logic [7:0] data);
		@(posedge clk);
		reg_adr <= reg_adr_e'(adr);
		reg_wd  <= data;
		reg_we  <= 1'b1;
	endtask

	task automatic end_write();
		@(posedge clk);  // write lands on this edge
		reg_we <= 1'b0;
	endtask

	task automatic write_reg(input logic [6:0] adr, input logic [7:0] data);
		start_write(adr, data);
		end_write();
	endtask

	task automatic read_reg(input logic [6:0] adr, output logic [7:0] data);
		@(posedge clk);
		reg_adr <= reg_adr_e'(adr);
		reg_we  <= 1'b0;
		@(negedge clk);
		data = reg_rd;
	endtask

	task automatic read_expect(input logic [6:0] adr, input logic [7:0] exp, input string what);
		logic [7:0] rd;
		read_reg(adr, rd);
		compare(what, 32'(rd), 32'(exp));
	endtask

	// readable bits per settings address
	function automatic logic [7:0] read_mask(input logic [6:0] adr);
		case (adr)
			ADR_CODE_BGN_MSB, ADR_CODE_END_MSB: return HI_MASK;
			ADR_CODE_IDX:                       return 8'h3F;
			default:                            return 8'hFF;
		endcase
	endfunction

	// **************************************************
	// directed tests
	// **************************************************
	task automatic reset_values();
		@(negedge clk);
		compare("control outputs after reset", 32'({sw_rst_o, clk_en_o, mode_o, start_o,
			stop_o, int_en_o, rx_gpio_en_o, rx_pol_inv_o, int_clr_o, mem_we}), 0);
		read_expect(ADR_RPT_DEL_0, 8'hBA, "repeat delay byte 0 reset");
		read_expect(ADR_RPT_DEL_1, 8'h50, "repeat delay byte 1 reset");
		read_expect(ADR_RPT_DEL_2, 8'h10, "repeat delay byte 2 reset");
		read_expect(ADR_ID_LSB, 8'h02, "id lsb");
		read_expect(ADR_ID_MSB, 8'h10, "id msb");
		read_expect(ADR_VER_LSB, 8'h01, "version lsb");
		read_expect(ADR_VER_MSB, 8'h00, "version msb");
	endtask

	task automatic settings_rw();
		int rnd;
		for (int i = 0; i < 13; i++) begin
			rnd = $random(seed);
			cfg_val[i] = rnd[7:0];
			write_reg(CFG_ADR[i], rnd[7:0]);
		end
		for (int i = 0; i < 13; i++)
			read_expect(CFG_ADR[i], cfg_val[i] & read_mask(CFG_ADR[i]),
				$sformatf("readback at %02h", CFG_ADR[i]));
		compare("tx carrier length port", 32'(tx_crr_len), 32'({cfg_val[4], cfg_val[3]}));
		compare("duty limit port", 32'(duty_limit), 32'({cfg_val[6], cfg_val[5]}));
		compare("repeat length port", 32'(rpt_len_rx_ctrl), 32'(cfg_val[11]));
		compare("code begin port", 32'(code_bgn), 32'({cfg_val[8] & HI_MASK, cfg_val[7]}));
		compare("code end port", 32'(tx_code_end), 32'({cfg_val[10] & HI_MASK, cfg_val[9]}));
	endtask

	task automatic cmd_status();
		write_reg(ADR_COMMAND, 8'h99);  // sw reset, mode, stop, start
		@(negedge clk);
		compare("sw_rst mode start stop set", 32'({sw_rst_o, mode_o, start_o, stop_o}), 'hF);
		read_expect(ADR_COMMAND, 8'h99, "command readback");
		@(posedge clk);
		start_clr <= 1'b1;
		@(negedge clk);
		compare("start held low by clear", 32'(start_o), 0);
		@(posedge clk);
		start_clr <= 1'b0;
		@(negedge clk);
		compare("start cleared, stop kept", 32'({start_o, stop_o}), 'h1);
		@(posedge clk);
		stop_clr <= 1'b1;
		@(posedge clk);
		stop_clr <= 1'b0;
		@(negedge clk);
		compare("stop cleared, mode kept", 32'({stop_o, mode_o}), 'h1);
		write_reg(ADR_COMMAND, 8'h00);

		write_reg(ADR_STAT_CTRL, 8'hF0);  // bit 3 low
		@(negedge clk);
		compare("int_clr pulse", 32'(int_clr_o), 1);
		compare("status enables", 32'({clk_en_o, int_en_o, rx_gpio_en_o, rx_pol_inv_o}), 'hF);
		@(negedge clk);
		compare("int_clr pulse ends", 32'(int_clr_o), 0);
		write_reg(ADR_STAT_CTRL, 8'hF8);  // bit 3 high, no pulse
		@(negedge clk);
		compare("no int_clr with bit 3 high", 32'(int_clr_o), 0);
		@(posedge clk);
		busy <= 1'b1;
		read_expect(ADR_STAT_CTRL, 8'hF1, "status with busy");
		@(posedge clk);
		busy <= 1'b0;
		irq  <= 1'b1;
		read_expect(ADR_STAT_CTRL, 8'hF8, "status with interrupt");
		@(posedge clk);
		irq <= 1'b0;
		write_reg(ADR_STAT_CTRL, 8'h08);
	endtask

	task automatic mode_readback();
		int          rnd;
		logic [15:0] rx_len;
		logic [15:0] rx_end;
		rnd    = $random(seed);
		rx_len = rnd[15:0];
		rx_end = rnd[31:16] & END_MASK;
		@(posedge clk);
		rx_crr_len  <= rx_len;
		rx_code_end <= rx_end[MEM_AW-1:0];
		write_reg(ADR_COMMAND, 8'h10);  // receive mode
		read_expect(ADR_CRR_CYC_LEN_LSB, rx_len[7:0], "rx carrier length lsb");
		read_expect(ADR_CRR_CYC_LEN_MSB, rx_len[15:8], "rx carrier length msb");
		read_expect(ADR_CODE_END_LSB, rx_end[7:0], "rx end address lsb");
		read_expect(ADR_CODE_END_MSB, rx_end[15:8], "rx end address msb");
		write_reg(ADR_COMMAND, 8'h00);
		read_expect(ADR_CRR_CYC_LEN_LSB, cfg_val[3], "tx carrier length lsb");
		read_expect(ADR_CRR_CYC_LEN_MSB, cfg_val[4], "tx carrier length msb");
		read_expect(ADR_CODE_END_LSB, cfg_val[9], "tx end address lsb");
		read_expect(ADR_CODE_END_MSB, cfg_val[10] & HI_MASK, "tx end address msb");
	endtask

	task automatic code_window();
		int         rnd;
		logic [5:0] idx;
		logic [4:0] k;
		idx = 6'h2D;
		write_reg(ADR_CODE_IDX, {2'b00, idx});
		for (int j = 0; j < 3; j++) begin
			k   = WIN_OFFS[j];
			rnd = $random(seed);
			start_write({2'b11, k}, rnd[7:0]);
			@(negedge clk);
			compare("mem_we in window", 32'(mem_we), 1);
			compare("mem_adr paging", 32'(mem_adr), 32'({idx, k}) & 32'(END_MASK));
			compare("mem_wd", 32'(mem_wd), 32'(rnd[7:0]));
			end_write();
			mem_rd <= rnd[15:8];
			read_expect({2'b11, k}, rnd[15:8], "code memory read");
		end
		start_write(ADR_COMMAND, 8'h00);
		@(negedge clk);
		compare("no mem_we outside window", 32'(mem_we), 0);
		compare("mem_adr offset outside window", 32'(mem_adr), 32'({idx, 5'd0}));
		end_write();
	endtask

	task automatic repeat_start();
		int   cnt;
		logic started;
		logic late_start;
		write_reg(ADR_RPT_DEL_0, 8'(RPT_N));
		write_reg(ADR_RPT_DEL_1, 8'h00);
		write_reg(ADR_RPT_DEL_2, 8'h00);
		write_reg(ADR_COMMAND, 8'h03);  // repeat, start
		@(negedge clk);
		compare("start set", 32'(start_o), 1);
		@(posedge clk);
		busy <= 1'b1;
		repeat (2) @(posedge clk);
		start_clr <= 1'b1;  // engine takes the first start
		@(posedge clk);
		start_clr <= 1'b0;
		@(negedge clk);
		compare("start cleared during busy", 32'(start_o), 0);
		repeat (3) @(posedge clk);
		busy    <= 1'b0;
		cnt     = 0;
		started = 1'b0;
		while (!started && cnt < RPT_N + 20) begin
			@(posedge clk);
			cnt++;
			@(negedge clk);
			started = start_o;
		end
		checks++;
		assert (started) else begin
			errors++;
			$display("start_o did not rise again after busy fell");
		end
		if (started) begin
			checks++;
			assert (cnt >= RPT_N + 3 && cnt <= RPT_N + 4) else begin
				errors++;
				$display("CHECK FAILED time %0t: start again after %0d cycles, expected %0d to %0d",
					$time, cnt, RPT_N + 3, RPT_N + 4);
			end
		end
		@(posedge clk);
		start_clr <= 1'b1;
		@(posedge clk);
		start_clr <= 1'b0;
		@(negedge clk);
		compare("repeated start taken", 32'(start_o), 0);

		write_reg(ADR_COMMAND, 8'h06);  // repeat-stop pulse clears the repeat bit set here
		read_expect(ADR_COMMAND, 8'h00, "repeat cleared by repeat-stop");
		@(posedge clk);
		busy <= 1'b1;
		repeat (6) @(posedge clk);
		busy       <= 1'b0;
		late_start = 1'b0;
		repeat (RPT_N + 10) begin
			@(negedge clk);
			late_start = late_start | start_o;
		end
		compare("no start after repeat-stop", 32'(late_start), 0);
	endtask

	// **************************************************
	// main sequence
	// **************************************************
	initial begin
		seed        = 32'h0a48_8740;
		cycles      = 0;
		checks      = 0;
		errors      = 0;
		rst         = 1'b1;
		reg_adr     = ADR_ID_LSB;
		reg_wd      = 8'h00;
		reg_we      = 1'b0;
		start_clr   = 1'b0;
		stop_clr    = 1'b0;
		busy        = 1'b0;
		irq         = 1'b0;
		rx_crr_len  = '0;
		rx_code_end = '0;
		mem_rd      = 8'h00;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		reset_values();
		settings_rw();
		cmd_status();
		mode_readback();
		code_window();
		repeat_start();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- src/ir_cfg_regs.sv
// byte-written timing, address and repeat-delay settings plus the paged code-memory write window
`timescale 1ns/1ps
module ir_cfg_regs #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  logic                             REG_CLK_i,
	input  logic                             RST_i,
	input  ir_reg_pkg::reg_adr_e             reg_adr_i,
	input  logic [ir_reg_pkg::REG_DAT_W-1:0] reg_wd_i,
	input  logic                             reg_we_i,
	output logic [15:0]                      tx_crr_cyc_len_o,
	output logic [15:0]                      duty_limit_o,
	output logic [ir_reg_pkg::REG_DAT_W-1:0] rpt_len_rx_ctrl_o,
	output logic [ir_reg_pkg::MEM_IDX_W-1:0] code_idx_o,
	output logic [MEM_ADR_WIDTH-1:0]         code_bgn_adr_o,
	output logic [MEM_ADR_WIDTH-1:0]         tx_code_end_adr_o,
	output logic [ir_reg_pkg::RPT_DEL_W-1:0] rpt_del_o,
	output logic                             mem_we_o,
	output logic [MEM_ADR_WIDTH-1:0]         mem_adr_o,
	output logic [ir_reg_pkg::REG_DAT_W-1:0] mem_wd_o
);
	import ir_reg_pkg::*;

	localparam int CAT_W = MEM_IDX_W + MEM_LSB_W;

	logic                 in_window;
	logic [MEM_LSB_W-1:0] mem_lsb;
	logic [CAT_W-1:0]     mem_adr_cat;

	// **************************************************
	// settings registers
	// **************************************************
	always_ff @(posedge REG_CLK_i or posedge RST_i) begin
		if (RST_i) begin
			tx_crr_cyc_len_o  <= '0;
			duty_limit_o      <= '0;
			rpt_len_rx_ctrl_o <= '0;
			code_idx_o        <= '0;
			code_bgn_adr_o    <= '0;
			tx_code_end_adr_o <= '0;
			rpt_del_o         <= RPT_DEL_RST;
		end else if (reg_we_i) begin
			case (reg_adr_i)
				ADR_RPT_DEL_0:       rpt_del_o[7:0]          <= reg_wd_i;
				ADR_RPT_DEL_1:       rpt_del_o[15:8]         <= reg_wd_i;
				ADR_RPT_DEL_2:       rpt_del_o[23:16]        <= reg_wd_i;
				ADR_CRR_CYC_LEN_LSB: tx_crr_cyc_len_o[7:0]   <= reg_wd_i;
				ADR_CRR_CYC_LEN_MSB: tx_crr_cyc_len_o[15:8]  <= reg_wd_i;
				ADR_DUTY_LIMIT_LSB:  duty_limit_o[7:0]       <= reg_wd_i;
				ADR_DUTY_LIMIT_MSB:  duty_limit_o[15:8]      <= reg_wd_i;
				ADR_RPT_LEN_RX_CTRL: rpt_len_rx_ctrl_o       <= reg_wd_i;
				ADR_CODE_IDX:        code_idx_o              <= reg_wd_i[MEM_IDX_W-1:0];
				ADR_CODE_BGN_LSB:    code_bgn_adr_o[7:0]     <= reg_wd_i;
				ADR_CODE_BGN_MSB:
					code_bgn_adr_o[MEM_ADR_WIDTH-1:8] <= reg_wd_i[MEM_ADR_WIDTH-9:0];
				ADR_CODE_END_LSB:    tx_code_end_adr_o[7:0]  <= reg_wd_i;
				ADR_CODE_END_MSB:
					tx_code_end_adr_o[MEM_ADR_WIDTH-1:8] <= reg_wd_i[MEM_ADR_WIDTH-9:0];
				default: ;  // read-only or code window
			endcase
		end
	end

	// **************************************************
	// code-memory window 60-7F
	// **************************************************
	assign in_window   = &reg_adr_i[6:5];
	assign mem_lsb     = in_window ? reg_adr_i[MEM_LSB_W-1:0] : '0;
	assign mem_adr_cat = {code_idx_o, mem_lsb};  // page index on top

	assign mem_we_o  = reg_we_i & in_window;
	assign mem_adr_o = MEM_ADR_WIDTH'(mem_adr_cat);
	assign mem_wd_o  = reg_wd_i;

endmodule

//--- src/ir_cmd_regs.sv
// command and status/control registers with engine clears and one-cycle pulses
`timescale 1ns/1ps
module ir_cmd_regs (
	input  logic                             REG_CLK_i,
	input  logic                             RST_i,
	input  ir_reg_pkg::reg_adr_e             reg_adr_i,
	input  logic [ir_reg_pkg::REG_DAT_W-1:0] reg_wd_i,
	input  logic                             reg_we_i,
	input  logic                             start_clr_i,
	input  logic                             stop_clr_i,
	output logic                             sw_rst_o,
	output logic                             mode_o,       // 0 tx, 1 rx
	output logic                             start_o,
	output logic                             stop_o,
	output logic                             repeat_o,
	output logic                             repeat_stop_o,
	output logic                             clk_en_o,
	output logic                             int_en_o,
	output logic                             rx_gpio_en_o,
	output logic                             rx_pol_inv_o,
	output logic                             int_clr_o
);
	import ir_reg_pkg::*;

	logic cmd_we;
	logic stat_we;
	logic start_q;
	logic stop_q;

	assign cmd_we  = reg_we_i & (reg_adr_i == ADR_COMMAND);
	assign stat_we = reg_we_i & (reg_adr_i == ADR_STAT_CTRL);

	// **************************************************
	// command register
	// **************************************************
	always_ff @(posedge REG_CLK_i or posedge RST_i) begin
		if (RST_i) begin
			sw_rst_o      <= 1'b0;
			mode_o        <= 1'b0;
			start_q       <= 1'b0;
			stop_q        <= 1'b0;
			repeat_o      <= 1'b0;
			repeat_stop_o <= 1'b0;
		end else begin
			if (cmd_we) begin
				sw_rst_o <= reg_wd_i[7];
				mode_o   <= reg_wd_i[4];
			end
			// engine clear wins over a new write
			if (start_clr_i)
				start_q <= 1'b0;
			else if (cmd_we)
				start_q <= reg_wd_i[0];
			if (stop_clr_i)
				stop_q <= 1'b0;
			else if (cmd_we)
				stop_q <= reg_wd_i[3];
			if (repeat_stop_o)
				repeat_o <= 1'b0;
			else if (cmd_we)
				repeat_o <= reg_wd_i[1];
			repeat_stop_o <= cmd_we & reg_wd_i[2];  // self clearing
		end
	end

	assign start_o = start_q & ~start_clr_i;  // held low while clear is up
	assign stop_o  = stop_q & ~stop_clr_i;

	// **************************************************
	// status / control register
	// **************************************************
	always_ff @(posedge REG_CLK_i or posedge RST_i) begin
		if (RST_i) begin
			clk_en_o     <= 1'b0;
			int_en_o     <= 1'b0;
			rx_gpio_en_o <= 1'b0;
			rx_pol_inv_o <= 1'b0;
			int_clr_o    <= 1'b0;
		end else begin
			if (stat_we) begin
				clk_en_o     <= reg_wd_i[7];
				int_en_o     <= reg_wd_i[6];
				rx_gpio_en_o <= reg_wd_i[5];
				rx_pol_inv_o <= reg_wd_i[4];
			end
			int_clr_o <= stat_we & ~reg_wd_i[3];  // bit 3 low clears the interrupt
		end
	end

endmodule

//--- src/ir_readback.sv
// combinational host read mux over registers, engine status and the code-memory window
`timescale 1ns/1ps
module ir_readback #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  ir_reg_pkg::reg_adr_e             reg_adr_i,
	input  logic                             mode_i,
	input  logic                             sw_rst_i,
	input  logic                             start_i,
	input  logic                             stop_i,
	input  logic                             repeat_i,
	input  logic                             repeat_stop_i,
	input  logic                             clk_en_i,
	input  logic                             int_en_i,
	input  logic                             rx_gpio_en_i,
	input  logic                             rx_pol_inv_i,
	input  logic [15:0]                      tx_crr_cyc_len_i,
	input  logic [15:0]                      duty_limit_i,
	input  logic [ir_reg_pkg::REG_DAT_W-1:0] rpt_len_rx_ctrl_i,
	input  logic [ir_reg_pkg::MEM_IDX_W-1:0] code_idx_i,
	input  logic [MEM_ADR_WIDTH-1:0]         code_bgn_adr_i,
	input  logic [MEM_ADR_WIDTH-1:0]         tx_code_end_adr_i,
	input  logic [ir_reg_pkg::RPT_DEL_W-1:0] rpt_del_i,
	input  logic                             int_i,
	input  logic                             busy_i,
	input  logic [15:0]                      rx_crr_cyc_len_i,
	input  logic [MEM_ADR_WIDTH-1:0]         rx_code_end_adr_i,
	input  logic [ir_reg_pkg::REG_DAT_W-1:0] mem_rd_i,
	output logic [ir_reg_pkg::REG_DAT_W-1:0] reg_rd_o
);
	import ir_reg_pkg::*;

	logic [15:0]              crr_len;   // tx or rx by mode
	logic [MEM_ADR_WIDTH-1:0] end_adr;

	assign crr_len = mode_i ? rx_crr_cyc_len_i : tx_crr_cyc_len_i;
	assign end_adr = mode_i ? rx_code_end_adr_i : tx_code_end_adr_i;

	always_comb begin
		case (reg_adr_i)
			ADR_RPT_DEL_0:       reg_rd_o = rpt_del_i[7:0];
			ADR_RPT_DEL_1:       reg_rd_o = rpt_del_i[15:8];
			ADR_RPT_DEL_2:       reg_rd_o = rpt_del_i[23:16];
			ADR_ID_LSB:          reg_rd_o = PSB_ID_LSB;
			ADR_ID_MSB:          reg_rd_o = PSB_ID_MSB;
			ADR_VER_LSB:         reg_rd_o = PSB_VER_LSB;
			ADR_VER_MSB:         reg_rd_o = PSB_VER_MSB;
			ADR_COMMAND:
				reg_rd_o = {sw_rst_i, 2'b00, mode_i, stop_i, repeat_stop_i, repeat_i, start_i};
			ADR_STAT_CTRL:
				reg_rd_o = {clk_en_i, int_en_i, rx_gpio_en_i, rx_pol_inv_i, int_i, 2'b00, busy_i};
			ADR_CRR_CYC_LEN_LSB: reg_rd_o = crr_len[7:0];
			ADR_CRR_CYC_LEN_MSB: reg_rd_o = crr_len[15:8];
			ADR_DUTY_LIMIT_LSB:  reg_rd_o = duty_limit_i[7:0];
			ADR_DUTY_LIMIT_MSB:  reg_rd_o = duty_limit_i[15:8];
			ADR_CODE_BGN_LSB:    reg_rd_o = code_bgn_adr_i[7:0];
			ADR_CODE_BGN_MSB:    reg_rd_o = REG_DAT_W'(code_bgn_adr_i[MEM_ADR_WIDTH-1:8]);
			ADR_CODE_END_LSB:    reg_rd_o = end_adr[7:0];
			ADR_CODE_END_MSB:    reg_rd_o = REG_DAT_W'(end_adr[MEM_ADR_WIDTH-1:8]);
			ADR_RPT_LEN_RX_CTRL: reg_rd_o = rpt_len_rx_ctrl_i;
			ADR_CODE_IDX:        reg_rd_o = REG_DAT_W'(code_idx_i);
			default:             reg_rd_o = (&reg_adr_i[6:5]) ? mem_rd_i : '0;  // code window
		endcase
	end

endmodule

//--- src/ir_reg_if.sv
// IR controller register block top; host register port, code-memory port and engine controls
`timescale 1ns/1ps
module ir_reg_if #(
	parameter int MEM_ADR_WIDTH = 11
) (
	input  logic                             REG_CLK_i,
	input  logic                             RST_i,
	// host port
	input  ir_reg_pkg::reg_adr_e             reg_adr_i,
	input  logic [ir_reg_pkg::REG_DAT_W-1:0] reg_wd_i,
	input  logic                             reg_we_i,
	output logic [ir_reg_pkg::REG_DAT_W-1:0] reg_rd_o,
	// engine controls and status
	output logic                             sw_rst_o,
	output logic                             clk_en_o,
	output logic                             mode_o,
	output logic                             start_o,
	input  logic                             start_clr_i,
	output logic                             stop_o,
	input  logic                             stop_clr_i,
	input  logic                             busy_i,
	output logic                             int_en_o,
	output logic                             rx_gpio_en_o,
	output logic                             rx_pol_inv_o,
	input  logic                             int_i,
	output logic                             int_clr_o,
	output logic [15:0]                      tx_crr_cyc_len_o,
	output logic [15:0]                      duty_limit_o,
	output logic [ir_reg_pkg::REG_DAT_W-1:0] rpt_len_rx_ctrl_o,
	output logic [MEM_ADR_WIDTH-1:0]         code_bgn_adr_o,
	output logic [MEM_ADR_WIDTH-1:0]         tx_code_end_adr_o,
	input  logic [15:0]                      rx_crr_cyc_len_i,
	input  logic [MEM_ADR_WIDTH-1:0]         rx_code_end_adr_i,
	// code memory
	output logic                             mem_we_o,
	output logic [MEM_ADR_WIDTH-1:0]         mem_adr_o,
	output logic [ir_reg_pkg::REG_DAT_W-1:0] mem_wd_o,
	input  logic [ir_reg_pkg::REG_DAT_W-1:0] mem_rd_i
);
	import ir_reg_pkg::*;

	logic                 start_reg;   // host start bit
	logic                 rpt_start;   // sequencer start request
	logic                 repeat_en;
	logic                 repeat_stop;
	logic [MEM_IDX_W-1:0] code_idx;
	logic [RPT_DEL_W-1:0] rpt_del;

	ir_cmd_regs u_cmd_regs (
		.REG_CLK_i     (REG_CLK_i),
		.RST_i         (RST_i),
		.reg_adr_i     (reg_adr_i),
		.reg_wd_i      (reg_wd_i),
		.reg_we_i      (reg_we_i),
		.start_clr_i   (start_clr_i),
		.stop_clr_i    (stop_clr_i),
		.sw_rst_o      (sw_rst_o),
		.mode_o        (mode_o),
		.start_o       (start_reg),
		.stop_o        (stop_o),
		.repeat_o      (repeat_en),
		.repeat_stop_o (repeat_stop),
		.clk_en_o      (clk_en_o),
		.int_en_o      (int_en_o),
		.rx_gpio_en_o  (rx_gpio_en_o),
		.rx_pol_inv_o  (rx_pol_inv_o),
		.int_clr_o     (int_clr_o)
	);

	ir_cfg_regs #(.MEM_ADR_WIDTH(MEM_ADR_WIDTH)) u_cfg_regs (
		.REG_CLK_i         (REG_CLK_i),
		.RST_i             (RST_i),
		.reg_adr_i         (reg_adr_i),
		.reg_wd_i          (reg_wd_i),
		.reg_we_i          (reg_we_i),
		.tx_crr_cyc_len_o  (tx_crr_cyc_len_o),
		.duty_limit_o      (duty_limit_o),
		.rpt_len_rx_ctrl_o (rpt_len_rx_ctrl_o),
		.code_idx_o        (code_idx),
		.code_bgn_adr_o    (code_bgn_adr_o),
		.tx_code_end_adr_o (tx_code_end_adr_o),
		.rpt_del_o         (rpt_del),
		.mem_we_o          (mem_we_o),
		.mem_adr_o         (mem_adr_o),
		.mem_wd_o          (mem_wd_o)
	);

	ir_repeat_seq u_repeat_seq (
		.REG_CLK_i     (REG_CLK_i),
		.RST_i         (RST_i),
		.start_i       (start_reg),
		.repeat_i      (repeat_en),
		.repeat_stop_i (repeat_stop),
		.start_clr_i   (start_clr_i),
		.busy_i        (busy_i),
		.rpt_del_i     (rpt_del),
		.rpt_start_o   (rpt_start)
	);

	ir_readback #(.MEM_ADR_WIDTH(MEM_ADR_WIDTH)) u_readback (
		.reg_adr_i         (reg_adr_i),
		.mode_i            (mode_o),
		.sw_rst_i          (sw_rst_o),
		.start_i           (start_reg),
		.stop_i            (stop_o),
		.repeat_i          (repeat_en),
		.repeat_stop_i     (repeat_stop),
		.clk_en_i          (clk_en_o),
		.int_en_i          (int_en_o),
		.rx_gpio_en_i      (rx_gpio_en_o),
		.rx_pol_inv_i      (rx_pol_inv_o),
		.tx_crr_cyc_len_i  (tx_crr_cyc_len_o),
		.duty_limit_i      (duty_limit_o),
		.rpt_len_rx_ctrl_i (rpt_len_rx_ctrl_o),
		.code_idx_i        (code_idx),
		.code_bgn_adr_i    (code_bgn_adr_o),
		.tx_code_end_adr_i (tx_code_end_adr_o),
		.rpt_del_i         (rpt_del),
		.int_i             (int_i),
		.busy_i            (busy_i),
		.rx_crr_cyc_len_i  (rx_crr_cyc_len_i),
		.rx_code_end_adr_i (rx_code_end_adr_i),
		.mem_rd_i          (mem_rd_i),
		.reg_rd_o          (reg_rd_o)
	);

	assign start_o = start_reg | rpt_start;  // host start or repeated start

endmodule

//--- src/ir_reg_pkg.sv
// shared widths, register map, sequencer states and constants; import into each IR register block
package ir_reg_pkg;

	// **************************************************
	// widths
	// **************************************************
	localparam int REG_ADR_W = 7;
	localparam int REG_DAT_W = 8;
	localparam int MEM_IDX_W = 6;  // code-memory page index
	localparam int MEM_LSB_W = 5;  // offset inside the 60-7F window
	localparam int RPT_DEL_W = 24;

	localparam logic [RPT_DEL_W-1:0] RPT_DEL_RST = 24'h1050BA;

	// identity and version bytes
	localparam logic [REG_DAT_W-1:0] PSB_ID_LSB  = 8'h02;
	localparam logic [REG_DAT_W-1:0] PSB_ID_MSB  = 8'h10;
	localparam logic [REG_DAT_W-1:0] PSB_VER_LSB = 8'h01;
	localparam logic [REG_DAT_W-1:0] PSB_VER_MSB = 8'h00;

	// **************************************************
	// register map, code window 60-7F not listed
	// **************************************************
	typedef enum logic [REG_ADR_W-1:0] {
		ADR_RPT_DEL_0       = 7'h40,
		ADR_RPT_DEL_1       = 7'h41,
		ADR_RPT_DEL_2       = 7'h42,
		ADR_ID_LSB          = 7'h50,
		ADR_ID_MSB          = 7'h51,
		ADR_VER_LSB         = 7'h52,
		ADR_VER_MSB         = 7'h53,
		ADR_COMMAND         = 7'h54,
		ADR_STAT_CTRL       = 7'h55,
		ADR_CRR_CYC_LEN_LSB = 7'h56,
		ADR_CRR_CYC_LEN_MSB = 7'h57,
		ADR_DUTY_LIMIT_LSB  = 7'h58,
		ADR_DUTY_LIMIT_MSB  = 7'h59,
		ADR_CODE_BGN_LSB    = 7'h5A,
		ADR_CODE_BGN_MSB    = 7'h5B,
		ADR_CODE_END_LSB    = 7'h5C,
		ADR_CODE_END_MSB    = 7'h5D,
		ADR_RPT_LEN_RX_CTRL = 7'h5E,
		ADR_CODE_IDX        = 7'h5F
	} reg_adr_e;

	// repeat-start sequencer
	typedef enum logic [2:0] {
		RPT_IDLE,
		RPT_WAIT_BUSY_HI,
		RPT_WAIT_BUSY_LO,
		RPT_RUN_DELAY,
		RPT_CHK
	} rpt_state_e;

endpackage

//--- src/ir_repeat_seq.sv
// repeat-start sequencer; after each busy period it counts the repeat delay and requests a new start
`timescale 1ns/1ps
module ir_repeat_seq (
	input  logic                             REG_CLK_i,
	input  logic                             RST_i,
	input  logic                             start_i,
	input  logic                             repeat_i,
	input  logic                             repeat_stop_i,
	input  logic                             start_clr_i,
	input  logic                             busy_i,
	input  logic [ir_reg_pkg::RPT_DEL_W-1:0] rpt_del_i,
	output logic                             rpt_start_o
);
	import ir_reg_pkg::*;

	logic                 busy_s1;
	logic                 busy_s2;
	rpt_state_e           state;
	logic [RPT_DEL_W-1:0] del_cnt;

	// busy comes from the engine side
	always_ff @(posedge REG_CLK_i or posedge RST_i) begin
		if (RST_i) begin
			busy_s1 <= 1'b0;
			busy_s2 <= 1'b0;
		end else begin
			busy_s1 <= busy_i;
			busy_s2 <= busy_s1;
		end
	end

	// **************************************************
	// sequencer
	// **************************************************
	always_ff @(posedge REG_CLK_i or posedge RST_i) begin
		if (RST_i) begin
			state       <= RPT_IDLE;
			del_cnt     <= '0;
			rpt_start_o <= 1'b0;
		end else if (repeat_stop_i) begin  // repeat-stop aborts everything
			state       <= RPT_IDLE;
			del_cnt     <= '0;
			rpt_start_o <= 1'b0;
		end else begin
			case (state)
				RPT_IDLE: begin
					del_cnt     <= '0;
					rpt_start_o <= 1'b0;
					if (start_i & repeat_i)
						state <= RPT_WAIT_BUSY_HI;
				end
				RPT_WAIT_BUSY_HI: begin
					del_cnt <= '0;
					if (busy_s2)
						state <= RPT_WAIT_BUSY_LO;
					if (start_clr_i)
						rpt_start_o <= 1'b0;  // engine took the request
				end
				RPT_WAIT_BUSY_LO: begin
					del_cnt <= '0;
					if (!busy_s2)
						state <= RPT_RUN_DELAY;
					if (start_clr_i)
						rpt_start_o <= 1'b0;
				end
				RPT_RUN_DELAY: begin
					del_cnt <= del_cnt + 1'b1;  // 0..N, N+1 cycles
					if (del_cnt == rpt_del_i) begin
						state       <= RPT_CHK;
						rpt_start_o <= 1'b1;
					end
				end
				RPT_CHK: begin
					del_cnt <= '0;
					if (!repeat_i)
						state <= RPT_IDLE;
					else if (busy_s2)
						state <= RPT_WAIT_BUSY_LO;
					else
						state <= RPT_WAIT_BUSY_HI;
				end
				default: state <= RPT_IDLE;
			endcase
		end
	end

endmodule
